/* Makefile */
VERILATOR ?= verilator
TOP       ?= ulpi_tx_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= vlog.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	-./$(BIN) $(SIM_ARGS) | tee $(LOG)
	@if grep -q "^>>> PASS$$" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/ulpi_pkg.sv */
package ulpi_pkg;

  // One byte on its way to the PHY, last marks the end of a transfer
  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } ulpi_tx_byte_t;

  // Input stream beat of a USB data packet
  // keep low with last high is a zero-length packet
  typedef struct packed {
    logic [7:0] data;
    logic       keep;
    logic       last;
    logic [3:0] pid;
  } usb_beat_t;

  // ULPI command prefixes
  localparam logic [7:0] ULPI_CMD_TX   = 8'h40;
  localparam logic [7:0] ULPI_CMD_REGW = 8'h80;

  localparam logic [15:0] CRC16_INIT = 16'hffff;

  // Reflected form of polynomial 0x8005
  localparam logic [15:0] CRC16_POLY_REV = 16'ha001;

  // Advance the USB CRC16 by one byte, LSB first
  function automatic logic [15:0] usb_crc16_next(
    input logic [15:0] crc,
    input logic [7:0]  data
  );
    logic [15:0] c;
    c = crc ^ {8'h00, data};
    for (int i = 0; i < 8; i++) begin
      if (c[0]) begin
        c = (c >> 1) ^ CRC16_POLY_REV;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

endpackage

/* src/phy_reg_source.sv */
module phy_reg_source
  import ulpi_pkg::*;
(
  input  logic          clock,
  input  logic          reset,
  input  logic          reg_write_i,
  input  logic [5:0]    reg_addr_i,
  input  logic [7:0]    reg_data_i,
  output logic          reg_busy_o,
  output logic          reg_valid_o,
  output ulpi_tx_byte_t reg_byte_o,
  input  logic          reg_ready_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_DATA
  } state_t;

  state_t     state_q;
  logic [5:0] addr_q;
  logic [7:0] data_q;
  logic       byte_move;

  assign byte_move   = reg_valid_o && reg_ready_i;
  assign reg_busy_o  = state_q != ST_IDLE;
  assign reg_valid_o = state_q != ST_IDLE;

  // REGW command byte first, then the value flagged last
  always_comb begin
    if (state_q == ST_DATA) begin
      reg_byte_o.data = data_q;
      reg_byte_o.last = 1'b1;
    end else begin
      reg_byte_o.data = ULPI_CMD_REGW | {2'b00, addr_q};
      reg_byte_o.last = 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: if (reg_write_i) state_q <= ST_ADDR;
        ST_ADDR: if (byte_move) state_q <= ST_DATA;
        ST_DATA: if (byte_move) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Request fields are only captured while idle
  always_ff @(posedge clock) begin
    if (state_q == ST_IDLE && reg_write_i) begin
      addr_q <= reg_addr_i;
      data_q <= reg_data_i;
    end
  end

endmodule

/* src/ulpi_tx_top.sv */
module ulpi_tx_top
  import ulpi_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       s_valid_i,
  input  usb_beat_t  s_beat_i,
  output logic       s_ready_o,
  input  logic       hsk_send_i,
  input  logic [3:0] hsk_pid_i,
  output logic       hsk_done_o,
  input  logic       reg_write_i,
  input  logic [5:0] reg_addr_i,
  input  logic [7:0] reg_data_i,
  output logic       reg_busy_o,
  output logic       pkt_done_o,
  output logic       reg_done_o,
  input  logic       ulpi_dir_i,
  input  logic       ulpi_nxt_i,
  output logic [7:0] ulpi_data_o,
  output logic       ulpi_stp_o
);

  logic          pkt_valid;
  ulpi_tx_byte_t pkt_byte;
  logic          pkt_ready;
  logic          reg_valid;
  ulpi_tx_byte_t reg_byte;
  logic          reg_ready;

  usb_packet_source u_pkt_src (
    .clock       (clock),
    .reset       (reset),
    .s_valid_i   (s_valid_i),
    .s_beat_i    (s_beat_i),
    .s_ready_o   (s_ready_o),
    .hsk_send_i  (hsk_send_i),
    .hsk_pid_i   (hsk_pid_i),
    .hsk_done_o  (hsk_done_o),
    .pkt_valid_o (pkt_valid),
    .pkt_byte_o  (pkt_byte),
    .pkt_ready_i (pkt_ready)
  );

  phy_reg_source u_reg_src (
    .clock       (clock),
    .reset       (reset),
    .reg_write_i (reg_write_i),
    .reg_addr_i  (reg_addr_i),
    .reg_data_i  (reg_data_i),
    .reg_busy_o  (reg_busy_o),
    .reg_valid_o (reg_valid),
    .reg_byte_o  (reg_byte),
    .reg_ready_i (reg_ready)
  );

  ulpi_encoder u_encoder (
    .clock       (clock),
    .reset       (reset),
    .pkt_valid_i (pkt_valid),
    .pkt_byte_i  (pkt_byte),
    .pkt_ready_o (pkt_ready),
    .reg_valid_i (reg_valid),
    .reg_byte_i  (reg_byte),
    .reg_ready_o (reg_ready),
    .pkt_done_o  (pkt_done_o),
    .reg_done_o  (reg_done_o),
    .ulpi_dir_i  (ulpi_dir_i),
    .ulpi_nxt_i  (ulpi_nxt_i),
    .ulpi_data_o (ulpi_data_o),
    .ulpi_stp_o  (ulpi_stp_o)
  );

endmodule

/* testbench/tb_clock_gen.sv */
module tb_clock_gen (
  output logic clock,
  output logic reset
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // Reset released a little after the 8th rising edge
  initial begin
    reset = 1'b1;
    repeat (8) @(posedge clock);
    #1 reset = 1'b0;
  end
endmodule

/* testbench/ulpi_tx_props.sv */
module ulpi_tx_props (
  input logic       clock,
  input logic       reset,
  input logic       ulpi_dir_i,
  input logic       ulpi_stp_o,
  input logic [7:0] ulpi_data_o,
  input logic       pkt_done_o,
  input logic       reg_done_o
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_cnt = 0;

  stp_single: assert property (@(posedge clock) disable iff (reset)
    ulpi_stp_o |=> !ulpi_stp_o)
    else begin
      $error("stp high for two cycles in a row");
      fail_cnt++;
    end

  // Link side stays quiet during bus turnaround
  turnaround_quiet: assert property (@(posedge clock) disable iff (reset)
    (ulpi_dir_i || $past(ulpi_dir_i)) |-> (!ulpi_stp_o && ulpi_data_o == 8'h00))
    else begin
      $error("stp or data driven during turnaround");
      fail_cnt++;
    end

  pkt_done_pulse: assert property (@(posedge clock) disable iff (reset)
    pkt_done_o |=> !pkt_done_o)
    else begin
      $error("pkt_done_o longer than one cycle");
      fail_cnt++;
    end

  reg_done_pulse: assert property (@(posedge clock) disable iff (reset)
    reg_done_o |=> !reg_done_o)
    else begin
      $error("reg_done_o longer than one cycle");
      fail_cnt++;
    end
endmodule

bind ulpi_encoder ulpi_tx_props u_props (
  .clock       (clock),
  .reset       (reset),
  .ulpi_dir_i  (ulpi_dir_i),
  .ulpi_stp_o  (ulpi_stp_o),
  .ulpi_data_o (ulpi_data_o),
  .pkt_done_o  (pkt_done_o),
  .reg_done_o  (reg_done_o)
);

/* testbench/ulpi_tx_tb.sv */
module ulpi_tx_tb
  import ulpi_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_DATA = 20;
  localparam int N_ZLP  = 8;
  localparam int N_HSK  = 10;
  localparam int N_REG  = 12;
  localparam int N_MIX  = 40;
  // Allow 20 cycles for each byte the tests send
  localparam int LIMIT_CYCLES =
    (N_DATA * 19 + N_ZLP * 3 + N_HSK + N_REG * 2 + N_MIX * 20) * 20;
  localparam logic [7:0] TX_CMD   = 8'h40;
  localparam logic [7:0] REGW_CMD = 8'h80;

  logic       clock;
  logic       reset;
  logic       s_valid = 1'b0;
  usb_beat_t  s_beat = '0;
  logic       s_ready;
  logic       hsk_send = 1'b0;
  logic [3:0] hsk_pid = 4'h0;
  logic       hsk_done;
  logic       reg_write = 1'b0;
  logic [5:0] reg_addr = 6'h00;
  logic [7:0] reg_data = 8'h00;
  logic       reg_busy;
  logic       pkt_done;
  logic       reg_done;
  logic       ulpi_dir = 1'b0;
  logic       ulpi_nxt = 1'b0;
  logic [7:0] ulpi_data;
  logic       ulpi_stp;

  integer     seed = 78941;
  usb_beat_t  beat_q[$];
  logic [7:0] exp_pkt_bytes[$];
  int         exp_pkt_lens[$];
  logic [7:0] exp_reg_bytes[$];
  int         exp_reg_lens[$];
  logic [7:0] rx_q[$];
  int         errors = 0;
  int         checks = 0;
  int         tests_failed = 0;
  int         err_mark = 0;
  int         pkt_done_cnt = 0;
  int         reg_done_cnt = 0;
  int         hsk_done_cnt = 0;
  logic       dir_en = 1'b0;
  int         dir_left = 0;
  logic       dir_prev = 1'b0;
  logic       active = 1'b0;
  logic       done_due = 1'b0;
  logic       done_is_reg = 1'b0;
  logic       moved;

  tb_clock_gen u_clk (.clock(clock), .reset(reset));

  ulpi_tx_top dut0 (
    .clock       (clock),
    .reset       (reset),
    .s_valid_i   (s_valid),
    .s_beat_i    (s_beat),
    .s_ready_o   (s_ready),
    .hsk_send_i  (hsk_send),
    .hsk_pid_i   (hsk_pid),
    .hsk_done_o  (hsk_done),
    .reg_write_i (reg_write),
    .reg_addr_i  (reg_addr),
    .reg_data_i  (reg_data),
    .reg_busy_o  (reg_busy),
    .pkt_done_o  (pkt_done),
    .reg_done_o  (reg_done),
    .ulpi_dir_i  (ulpi_dir),
    .ulpi_nxt_i  (ulpi_nxt),
    .ulpi_data_o (ulpi_data),
    .ulpi_stp_o  (ulpi_stp)
  );

  task automatic check_equal(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // USB CRC16 on a reflected register one bit at a time
  function automatic logic [15:0] crc16_step(input logic [15:0] crc, input logic [7:0] b);
    logic [15:0] r;
    logic        fb;
    r = crc;
    for (int i = 0; i < 8; i++) begin
      fb = r[0] ^ b[i];
      r  = r >> 1;
      if (fb) r = r ^ 16'ha001;
    end
    return r;
  endfunction

  // PHY model with random nxt and short dir bursts
  always @(posedge clock) begin
    #1;
    if (reset) begin
      ulpi_nxt = 1'b0;
      ulpi_dir = 1'b0;
    end else begin
      ulpi_nxt = ($random(seed) & 3) != 0;
      if (dir_left > 0) begin
        ulpi_dir = 1'b1;
        dir_left--;
      end else if (dir_en && ($random(seed) & 15) == 0) begin
        ulpi_dir = 1'b1;
        dir_left = $unsigned($random(seed)) % 4;
      end else begin
        ulpi_dir = 1'b0;
      end
    end
  end

  // Beats of one packet follow back to back on the input stream
  always @(posedge clock) begin
    moved = s_valid && s_ready;
    #1;
    if (moved) void'(beat_q.pop_front());
    s_valid = beat_q.size() != 0;
    s_beat  = (beat_q.size() != 0) ? beat_q[0] : '0;
  end

  task automatic close_transfer();
    int         n;
    logic       is_reg;
    logic [7:0] e;
    is_reg = rx_q[0][7:6] == 2'b10;
    if (is_reg && exp_reg_lens.size() != 0) begin
      n = exp_reg_lens.pop_front();
      check_equal("register transfer length", rx_q.size(), n);
      for (int i = 0; i < n; i++) begin
        e = exp_reg_bytes.pop_front();
        if (i < rx_q.size()) check_equal("register transfer byte", rx_q[i], e);
      end
    end else if (!is_reg && exp_pkt_lens.size() != 0) begin
      n = exp_pkt_lens.pop_front();
      check_equal("packet transfer length", rx_q.size(), n);
      for (int i = 0; i < n; i++) begin
        e = exp_pkt_bytes.pop_front();
        if (i < rx_q.size()) check_equal("packet transfer byte", rx_q[i], e);
      end
      // Every beat of the packet went through s_ready_o before its stp
      check_equal("input beats left at packet end", beat_q.size(), 0);
    end else begin
      errors++;
      $display("A transfer arrived at %0d ns with no request waiting for it", $time);
    end
    done_due    = 1'b1;
    done_is_reg = is_reg;
  endtask

  // Bytes count on nxt outside turnaround
  always @(posedge clock) begin
    if (!reset) begin
      if (done_due) begin
        check_equal("pkt_done_o after stp", pkt_done, !done_is_reg);
        check_equal("reg_done_o after stp", reg_done, done_is_reg);
        done_due = 1'b0;
      end
      if (pkt_done) pkt_done_cnt++;
      if (hsk_done) hsk_done_cnt++;
      if (reg_done) begin
        reg_done_cnt++;
        check_equal("reg_busy_o at reg_done_o", reg_busy, 0);
      end
      if (ulpi_stp) begin
        if (!active) begin
          errors++;
          $display("stp seen at %0d ns with no transfer in progress", $time);
        end else begin
          close_transfer();
        end
        active = 1'b0;
        rx_q.delete();
      end else if (ulpi_nxt && !ulpi_dir && !dir_prev) begin
        if (active || ulpi_data != 8'h00) begin
          active = 1'b1;
          rx_q.push_back(ulpi_data);
        end
      end
    end
    dir_prev = ulpi_dir;
  end

  task automatic send_data_packet(input int len);
    logic [3:0]  pid;
    logic [15:0] crc;
    logic [7:0]  b;
    usb_beat_t   beat;
    pid = 4'($random(seed));
    crc = 16'hffff;
    exp_pkt_bytes.push_back(TX_CMD | {4'h0, pid});
    if (len == 0) begin
      beat = '{data: 8'h00, keep: 1'b0, last: 1'b1, pid: pid};
      beat_q.push_back(beat);
    end
    for (int i = 0; i < len; i++) begin
      b   = 8'($random(seed));
      crc = crc16_step(crc, b);
      exp_pkt_bytes.push_back(b);
      beat = '{data: b, keep: 1'b1, last: (i == len - 1), pid: pid};
      beat_q.push_back(beat);
    end
    exp_pkt_bytes.push_back(~crc[7:0]);
    exp_pkt_bytes.push_back(~crc[15:8]);
    exp_pkt_lens.push_back(len + 3);
    do @(posedge clock); while (!pkt_done);
    #1;
  endtask

  task automatic send_handshake();
    logic [3:0] pid;
    pid = 4'($random(seed));
    exp_pkt_bytes.push_back(TX_CMD | {4'h0, pid});
    exp_pkt_lens.push_back(1);
    hsk_pid  = pid;
    hsk_send = 1'b1;
    do @(posedge clock); while (!hsk_done);
    #1 hsk_send = 1'b0;
    do @(posedge clock); while (!pkt_done);
    #1;
  endtask

  task automatic send_reg_write();
    logic [5:0] addr;
    logic [7:0] data;
    addr = 6'($random(seed));
    data = 8'($random(seed));
    while (reg_busy) begin
      @(posedge clock);
      #1;
    end
    exp_reg_bytes.push_back(REGW_CMD | {2'b00, addr});
    exp_reg_bytes.push_back(data);
    exp_reg_lens.push_back(2);
    reg_addr  = addr;
    reg_data  = data;
    reg_write = 1'b1;
    @(posedge clock);
    #1 reg_write = 1'b0;
    check_equal("reg_busy_o after strobe", reg_busy, 1);
    do @(posedge clock); while (!reg_done);
    #1;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clock);
      #1;
    end
  endtask

  task automatic start_test();
    err_mark     = errors;
    pkt_done_cnt = 0;
    reg_done_cnt = 0;
    hsk_done_cnt = 0;
  endtask

  task automatic finish_test(input string name, input int pkt_n, input int hsk_n,
                             input int reg_n);
    idle_cycles(4);
    check_equal("pkt_done_o count", pkt_done_cnt, pkt_n);
    check_equal("hsk_done_o count", hsk_done_cnt, hsk_n);
    check_equal("reg_done_o count", reg_done_cnt, reg_n);
    check_equal("transfers still expected", exp_pkt_lens.size() + exp_reg_lens.size(), 0);
    if (errors == err_mark) begin
      $display("Test %s: passed", name);
    end else begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", name, errors - err_mark);
    end
  endtask

  task automatic run_mixed();
    int n_hsk;
    int sel;
    n_hsk = 0;
    dir_en = 1'b1;
    fork
      begin
        for (int i = 0; i < N_MIX; i++) begin
          sel = $unsigned($random(seed)) % 8;
          if (sel < 4) begin
            send_data_packet(1 + $unsigned($random(seed)) % 16);
          end else if (sel < 6) begin
            send_data_packet(0);
          end else begin
            send_handshake();
            n_hsk++;
          end
          idle_cycles($unsigned($random(seed)) % 4);
        end
      end
      begin
        for (int i = 0; i < N_MIX / 2; i++) begin
          idle_cycles($unsigned($random(seed)) % 6);
          send_reg_write();
        end
      end
    join
    dir_en = 1'b0;
    finish_test("mixed traffic", N_MIX, n_hsk, N_MIX / 2);
  endtask

  initial begin
    while (reset !== 1'b0) @(posedge clock);
    idle_cycles(2);

    start_test();
    for (int i = 0; i < N_DATA; i++) send_data_packet(1 + $unsigned($random(seed)) % 16);
    finish_test("data packets", N_DATA, 0, 0);

    start_test();
    for (int i = 0; i < N_ZLP; i++) send_data_packet(0);
    finish_test("zero-length packets", N_ZLP, 0, 0);

    start_test();
    for (int i = 0; i < N_HSK; i++) send_handshake();
    finish_test("handshakes", N_HSK, N_HSK, 0);

    start_test();
    for (int i = 0; i < N_REG; i++) send_reg_write();
    finish_test("register writes", 0, 0, N_REG);

    start_test();
    run_mixed();

    errors = errors + dut0.u_encoder.u_props.fail_cnt;
    $display("Tests run 5, failed %0d; checks %0d, errors %0d", tests_failed, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    repeat (LIMIT_CYCLES) @(posedge clock);
    $display("Timeout: the tests did not finish within %0d cycles", LIMIT_CYCLES);
    $display(">>> FAIL");
    $finish;
  end
endmodule

/* ulpi_encoder/skid_loader.sv */
module skid_loader
  import ulpi_pkg::*;
(
  input  logic          clock,
  input  logic          reset,
  input  logic          s_valid_i,
  input  ulpi_tx_byte_t s_byte_i,
  output logic          s_ready_o,
  output logic          m_valid_o,
  output ulpi_tx_byte_t m_byte_o,
  input  logic          m_ready_i
);

  logic          m_valid_q;
  ulpi_tx_byte_t m_byte_q;
  logic          ov_valid_q;
  ulpi_tx_byte_t ov_byte_q;
  logic          s_fire;
  logic          out_free;

  // Ready comes from a register, so nxt never reaches the sources
  assign s_ready_o = !ov_valid_q;
  assign m_valid_o = m_valid_q;
  assign m_byte_o  = m_byte_q;

  assign s_fire   = s_valid_i && s_ready_o;
  assign out_free = !m_valid_q || m_ready_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      m_valid_q  <= 1'b0;
      ov_valid_q <= 1'b0;
    end else if (out_free) begin
      // Overflow entry drains first to keep byte order
      if (ov_valid_q) begin
        m_valid_q  <= 1'b1;
        ov_valid_q <= 1'b0;
      end else begin
        m_valid_q <= s_fire;
      end
    end else if (s_fire) begin
      ov_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (out_free) begin
      if (ov_valid_q) begin
        m_byte_q <= ov_byte_q;
      end else if (s_fire) begin
        m_byte_q <= s_byte_i;
      end
    end else if (s_fire) begin
      ov_byte_q <= s_byte_i;
    end
  end

endmodule

/* ulpi_encoder/ulpi_encoder.sv */
module ulpi_encoder
  import ulpi_pkg::*;
(
  input  logic          clock,
  input  logic          reset,
  input  logic          pkt_valid_i,
  input  ulpi_tx_byte_t pkt_byte_i,
  output logic          pkt_ready_o,
  input  logic          reg_valid_i,
  input  ulpi_tx_byte_t reg_byte_i,
  output logic          reg_ready_o,
  output logic          pkt_done_o,
  output logic          reg_done_o,
  input  logic          ulpi_dir_i,
  input  logic          ulpi_nxt_i,
  output logic [7:0]    ulpi_data_o,
  output logic          ulpi_stp_o
);

  typedef enum logic [1:0] {
    OWN_NONE,
    OWN_REG,
    OWN_PKT
  } owner_t;

  owner_t        owner_q;
  logic          feed_q;
  logic          dir_q;
  logic          stp_pend_q;
  logic          pkt_done_q;
  logic          reg_done_q;
  logic          turnaround;
  logic          sel_valid;
  ulpi_tx_byte_t sel_byte;
  logic          skid_valid;
  logic          skid_ready;
  logic          out_valid;
  ulpi_tx_byte_t out_byte;
  logic          out_ready;
  logic          load;
  logic          accept;

  // PHY owns the bus now or turned it around last cycle
  assign turnaround = ulpi_dir_i || dir_q;

  always_comb begin
    sel_valid = 1'b0;
    sel_byte  = reg_byte_i;
    case (owner_q)
      OWN_REG: begin
        sel_valid = reg_valid_i;
        sel_byte  = reg_byte_i;
      end
      OWN_PKT: begin
        sel_valid = pkt_valid_i;
        sel_byte  = pkt_byte_i;
      end
      default: ;
    endcase
  end

  assign skid_valid  = feed_q && !turnaround && sel_valid;
  assign load        = skid_valid && skid_ready;
  assign reg_ready_o = feed_q && !turnaround && skid_ready && owner_q == OWN_REG;
  assign pkt_ready_o = feed_q && !turnaround && skid_ready && owner_q == OWN_PKT;

  assign out_ready = ulpi_nxt_i && !turnaround;
  assign accept    = out_valid && out_ready;

  assign ulpi_data_o = (out_valid && !turnaround) ? out_byte.data : 8'h00;
  assign ulpi_stp_o  = stp_pend_q && !turnaround;
  assign pkt_done_o  = pkt_done_q;
  assign reg_done_o  = reg_done_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      dir_q      <= 1'b0;
      owner_q    <= OWN_NONE;
      feed_q     <= 1'b0;
      stp_pend_q <= 1'b0;
      pkt_done_q <= 1'b0;
      reg_done_q <= 1'b0;
    end else begin
      dir_q      <= ulpi_dir_i;
      pkt_done_q <= ulpi_stp_o && owner_q == OWN_PKT;
      reg_done_q <= ulpi_stp_o && owner_q == OWN_REG;

      // stp waits out a turnaround that starts right after the last byte
      if (accept && out_byte.last) begin
        stp_pend_q <= 1'b1;
      end else if (ulpi_stp_o) begin
        stp_pend_q <= 1'b0;
      end

      if (owner_q == OWN_NONE) begin
        // Register commands win over packets
        if (reg_valid_i) begin
          owner_q <= OWN_REG;
          feed_q  <= 1'b1;
        end else if (pkt_valid_i) begin
          owner_q <= OWN_PKT;
          feed_q  <= 1'b1;
        end
      end else begin
        if (load && sel_byte.last) begin
          feed_q <= 1'b0;
        end
        if (ulpi_stp_o) begin
          owner_q <= OWN_NONE;
        end
      end
    end
  end

  skid_loader u_skid (
    .clock     (clock),
    .reset     (reset),
    .s_valid_i (skid_valid),
    .s_byte_i  (sel_byte),
    .s_ready_o (skid_ready),
    .m_valid_o (out_valid),
    .m_byte_o  (out_byte),
    .m_ready_i (out_ready)
  );

endmodule

/* usb_tx/usb_packet_source.sv */
module usb_packet_source
  import ulpi_pkg::*;
(
  input  logic          clock,
  input  logic          reset,
  input  logic          s_valid_i,
  input  usb_beat_t     s_beat_i,
  output logic          s_ready_o,
  input  logic          hsk_send_i,
  input  logic [3:0]    hsk_pid_i,
  output logic          hsk_done_o,
  output logic          pkt_valid_o,
  output ulpi_tx_byte_t pkt_byte_o,
  input  logic          pkt_ready_i
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_PID,
    ST_DATA,
    ST_CRC_LO,
    ST_CRC_HI
  } state_t;

  state_t      state_q;
  logic        is_hsk_q;
  logic [3:0]  pid_q;
  logic [15:0] crc_q;
  logic        hsk_done_q;
  logic        byte_move;
  logic        zlp;
  logic [15:0] crc_tx;

  assign zlp       = s_beat_i.last && !s_beat_i.keep;
  assign crc_tx    = ~crc_q;
  assign byte_move = pkt_valid_o && pkt_ready_i;

  assign hsk_done_o = hsk_done_q;

  always_comb begin
    pkt_valid_o = 1'b0;
    pkt_byte_o  = '0;
    s_ready_o   = 1'b0;
    case (state_q)
      ST_PID: begin
        pkt_valid_o     = 1'b1;
        pkt_byte_o.data = ULPI_CMD_TX | {4'h0, pid_q};
        pkt_byte_o.last = is_hsk_q;
        // An empty packet gives up its only beat along with the TX CMD
        s_ready_o = pkt_ready_i && !is_hsk_q && zlp;
      end
      ST_DATA: begin
        pkt_valid_o     = s_valid_i;
        pkt_byte_o.data = s_beat_i.data;
        s_ready_o       = pkt_ready_i;
      end
      ST_CRC_LO: begin
        pkt_valid_o     = 1'b1;
        pkt_byte_o.data = crc_tx[7:0];
      end
      ST_CRC_HI: begin
        pkt_valid_o     = 1'b1;
        pkt_byte_o.data = crc_tx[15:8];
        pkt_byte_o.last = 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q    <= ST_IDLE;
      is_hsk_q   <= 1'b0;
      pid_q      <= 4'h0;
      crc_q      <= CRC16_INIT;
      hsk_done_q <= 1'b0;
    end else begin
      hsk_done_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          crc_q <= CRC16_INIT;
          // Handshakes go first, done blocks a second start on the same request
          if (hsk_send_i && !hsk_done_q) begin
            state_q  <= ST_PID;
            is_hsk_q <= 1'b1;
            pid_q    <= hsk_pid_i;
          end else if (s_valid_i) begin
            state_q  <= ST_PID;
            is_hsk_q <= 1'b0;
            pid_q    <= s_beat_i.pid;
          end
        end
        ST_PID: begin
          if (byte_move) begin
            if (is_hsk_q) begin
              state_q    <= ST_IDLE;
              hsk_done_q <= 1'b1;
            end else if (zlp) begin
              state_q <= ST_CRC_LO;
            end else begin
              state_q <= ST_DATA;
            end
          end
        end
        ST_DATA: begin
          if (byte_move) begin
            crc_q <= usb_crc16_next(crc_q, s_beat_i.data);
            if (s_beat_i.last) begin
              state_q <= ST_CRC_LO;
            end
          end
        end
        ST_CRC_LO: begin
          if (byte_move) begin
            state_q <= ST_CRC_HI;
          end
        end
        ST_CRC_HI: begin
          if (byte_move) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

endmodule

/* vlog.f */
common/ulpi_pkg.sv
usb_tx/usb_packet_source.sv
src/phy_reg_source.sv
ulpi_encoder/skid_loader.sv
ulpi_encoder/ulpi_encoder.sv
src/ulpi_tx_top.sv
testbench/tb_clock_gen.sv
testbench/ulpi_tx_props.sv
testbench/ulpi_tx_tb.sv
